/* design/hsk_consts.svh */
`ifndef HSK_CONSTS_SVH
`define HSK_CONSTS_SVH

//////////////////////////////////////////////////
// Serial timing at 80 MHz init_clk
//////////////////////////////////////////////////

// Clock cycles per bit, 0.5 Mbaud
`define HSK_BAUD_PERIOD 160
// Sample late in the bit, slow open-drain rise
`define HSK_SAMPLE_POINT 120
// Baud counter width, must hold HSK_BAUD_PERIOD-1
`define HSK_BAUD_CNT_W 8

//////////////////////////////////////////////////
// Data path widths and FIFO sizing
//////////////////////////////////////////////////

`define HSK_BYTE_W 8
`define HSK_BIT_IDX_W 4
`define HSK_BYTE_CNT_W 8
// Byte FIFO entries, power of two
`define HSK_FIFO_DEPTH 16
`define HSK_FIFO_AW 4

`endif

/* design/hsk_pkg.sv */
`include "hsk_consts.svh"

package hsk_pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    // One serial data byte
    typedef logic [`HSK_BYTE_W-1:0] byte_t;
    // Cycle counter within one bit
    typedef logic [`HSK_BAUD_CNT_W-1:0] baud_cnt_t;
    // Bit position inside a frame
    typedef logic [`HSK_BIT_IDX_W-1:0] bit_idx_t;
    // Extra MSB tells full from empty
    typedef logic [`HSK_FIFO_AW:0] fifo_ptr_t;
    // Wrapping count of accepted bytes
    typedef logic [`HSK_BYTE_CNT_W-1:0] byte_cnt_t;

    // Receiver output, valid is a single-cycle strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } rx_byte_s;

    // FIFO head, data good while avail is high
    typedef struct packed {
        logic  avail;
        byte_t data;
    } fifo_out_s;

    //////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage

/* design/hsk_uart_rx.sv */
`timescale 1ns/1ps
`include "hsk_consts.svh"

module hsk_uart_rx (
    input  logic                init_clk,
    input  logic                reset_i,
    input  logic                line_i,
    output hsk_pkg::rx_byte_s   rx_byte_o,
    output hsk_pkg::byte_cnt_t  rx_bytes_o
);

    // Two-flop retime of the open-drain crate line
    logic [1:0]          sync_q;
    // Previous synchronized value, for edge detect
    logic                line_q;
    hsk_pkg::rx_state_e  state_q;
    hsk_pkg::baud_cnt_t  baud_cnt_q;
    hsk_pkg::bit_idx_t   bit_idx_q;
    hsk_pkg::byte_t      shift_q;
    logic                valid_q;
    hsk_pkg::byte_cnt_t  bytes_q;

    logic line_s;
    logic fall_s;
    logic sample_s;
    logic bit_end_s;

    assign line_s    = sync_q[1];
    assign fall_s    = line_q & ~line_s;
    assign sample_s  = (baud_cnt_q == hsk_pkg::baud_cnt_t'(`HSK_SAMPLE_POINT));
    assign bit_end_s = (baud_cnt_q == hsk_pkg::baud_cnt_t'(`HSK_BAUD_PERIOD - 1));

    //////////////////////////////////////////////////
    // Synchronizer, idles high
    //////////////////////////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            sync_q <= 2'b11;
            line_q <= 1'b1;
        end else begin
            sync_q <= {sync_q[0], line_i};
            line_q <= line_s;
        end
    end

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            state_q    <= hsk_pkg::RX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            valid_q    <= 1'b0;
            bytes_q    <= '0;
        end else begin
            // Strobe lasts one cycle only
            valid_q <= 1'b0;
            if (state_q != hsk_pkg::RX_IDLE) begin
                baud_cnt_q <= bit_end_s ? '0 : baud_cnt_q + 1'b1;
            end
            case (state_q)
                hsk_pkg::RX_IDLE: begin
                    // Edge cycle counts as cycle 0 of the start bit
                    if (fall_s) begin
                        state_q    <= hsk_pkg::RX_START;
                        baud_cnt_q <= hsk_pkg::baud_cnt_t'(1);
                    end
                end
                hsk_pkg::RX_START: begin
                    // Glitch, not a real start bit
                    if (sample_s && line_s) begin
                        state_q <= hsk_pkg::RX_IDLE;
                    end else if (bit_end_s) begin
                        state_q   <= hsk_pkg::RX_DATA;
                        bit_idx_q <= '0;
                    end
                end
                hsk_pkg::RX_DATA: begin
                    if (bit_end_s) begin
                        if (bit_idx_q == hsk_pkg::bit_idx_t'(7)) begin
                            state_q <= hsk_pkg::RX_STOP;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                end
                hsk_pkg::RX_STOP: begin
                    // Bad stop bit drops the byte silently
                    if (sample_s) begin
                        state_q <= hsk_pkg::RX_IDLE;
                        if (line_s) begin
                            valid_q <= 1'b1;
                            bytes_q <= bytes_q + 1'b1;
                        end
                    end
                end
                default: state_q <= hsk_pkg::RX_IDLE;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge init_clk) begin
        if (state_q == hsk_pkg::RX_DATA && sample_s) begin
            shift_q <= {line_s, shift_q[7:1]};
        end
    end

    assign rx_byte_o  = '{valid: valid_q, data: shift_q};
    assign rx_bytes_o = bytes_q;

endmodule

/* design/hsk_byte_fifo.sv */
`timescale 1ns/1ps
`include "hsk_consts.svh"

module hsk_byte_fifo (
    input  logic                init_clk,
    input  logic                reset_i,
    input  hsk_pkg::rx_byte_s   wr_i,
    input  logic                pop_i,
    output hsk_pkg::fifo_out_s  head_o,
    output logic                overflow_o
);

    // Byte storage
    hsk_pkg::byte_t     mem_q [`HSK_FIFO_DEPTH];
    hsk_pkg::fifo_ptr_t wr_ptr_q;
    hsk_pkg::fifo_ptr_t rd_ptr_q;
    logic               overflow_q;

    logic empty_s;
    logic full_s;
    logic do_pop_s;
    logic do_wr_s;

    //////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////

    // Same index, MSBs differ when wrapped
    assign empty_s = (wr_ptr_q == rd_ptr_q);
    assign full_s  = (wr_ptr_q[`HSK_FIFO_AW] != rd_ptr_q[`HSK_FIFO_AW]) &&
                     (wr_ptr_q[`HSK_FIFO_AW-1:0] == rd_ptr_q[`HSK_FIFO_AW-1:0]);

    assign do_pop_s = pop_i & ~empty_s;
    // A pop in the same cycle frees the slot
    assign do_wr_s  = wr_i.valid & (~full_s | do_pop_s);

    //////////////////////////////////////////////////
    // Pointers and overflow
    //////////////////////////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_wr_s) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop_s) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Sticky until reset
            if (wr_i.valid && !do_wr_s) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge init_clk) begin
        if (do_wr_s) begin
            mem_q[wr_ptr_q[`HSK_FIFO_AW-1:0]] <= wr_i.data;
        end
    end

    // Head is read combinationally
    assign head_o     = '{avail: ~empty_s, data: mem_q[rd_ptr_q[`HSK_FIFO_AW-1:0]]};
    assign overflow_o = overflow_q;

endmodule

/* design/hsk_uart_tx.sv */
`timescale 1ns/1ps
`include "hsk_consts.svh"

module hsk_uart_tx (
    input  logic                init_clk,
    input  logic                reset_i,
    input  hsk_pkg::fifo_out_s  head_i,
    output logic                pop_o,
    output logic                line_o
);

    hsk_pkg::tx_state_e  state_q;
    hsk_pkg::baud_cnt_t  baud_cnt_q;
    hsk_pkg::bit_idx_t   bit_idx_q;
    hsk_pkg::byte_t      shift_q;
    // Registered line, idles high
    logic                line_q;

    logic bit_end_s;

    assign bit_end_s = (baud_cnt_q == hsk_pkg::baud_cnt_t'(`HSK_BAUD_PERIOD - 1));
    // Take the head as soon as we are free
    assign pop_o     = (state_q == hsk_pkg::TX_IDLE) & head_i.avail;

    //////////////////////////////////////////////////
    // Serializer FSM
    //////////////////////////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            state_q    <= hsk_pkg::TX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            line_q     <= 1'b1;
        end else begin
            if (state_q != hsk_pkg::TX_IDLE) begin
                baud_cnt_q <= bit_end_s ? '0 : baud_cnt_q + 1'b1;
            end
            case (state_q)
                hsk_pkg::TX_IDLE: begin
                    line_q <= 1'b1;
                    if (pop_o) begin
                        // Start bit goes out next cycle
                        state_q    <= hsk_pkg::TX_START;
                        baud_cnt_q <= '0;
                        line_q     <= 1'b0;
                    end
                end
                hsk_pkg::TX_START: begin
                    if (bit_end_s) begin
                        state_q   <= hsk_pkg::TX_DATA;
                        bit_idx_q <= '0;
                        line_q    <= shift_q[0];
                    end
                end
                hsk_pkg::TX_DATA: begin
                    if (bit_end_s) begin
                        if (bit_idx_q == hsk_pkg::bit_idx_t'(7)) begin
                            state_q <= hsk_pkg::TX_STOP;
                            line_q  <= 1'b1;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            line_q    <= shift_q[0];
                        end
                    end
                end
                hsk_pkg::TX_STOP: begin
                    if (bit_end_s) begin
                        state_q <= hsk_pkg::TX_IDLE;
                    end
                end
                default: state_q <= hsk_pkg::TX_IDLE;
            endcase
        end
    end

    // Byte loads on pop, then drops one bit per boundary
    always_ff @(posedge init_clk) begin
        if (pop_o) begin
            shift_q <= head_i.data;
        end else if (bit_end_s &&
                     (state_q == hsk_pkg::TX_START || state_q == hsk_pkg::TX_DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign line_o = line_q;

endmodule

/* design/hsk_bridge_top.sv */
`timescale 1ns/1ps

module hsk_bridge_top (
    input  logic                init_clk,
    input  logic                reset_i,
    // Crate transmit, open drain
    input  logic                surf_tx_i,
    // TURF serial receive
    input  logic                trx_i,
    // TURF serial path enable, active low
    input  logic                tctrl_b_i,
    // Debug port receive
    input  logic                dbg_rx_i,
    // Route crate bus to the debug port
    input  logic                hskbus_local_i,
    input  logic                crate_enable_i,
    output logic                surf_rx_o,
    output logic                f_ttx_o,
    output logic                dbg_tx_o,
    output hsk_pkg::byte_cnt_t  hskbus_rx_bytes_o,
    output logic                overflow_o
);

    logic               crate_line;
    hsk_pkg::rx_byte_s  rx_byte;
    hsk_pkg::fifo_out_s fifo_head;
    logic               tx_pop;
    logic               tx_line;
    logic               turf_line;

    //////////////////////////////////////////////////
    // Downstream, to the SURFs
    //////////////////////////////////////////////////

    // TURF line only counts with its serial path enabled
    assign turf_line = tctrl_b_i ? 1'b1 : trx_i;

    // Idle high while the bridge is off
    assign surf_rx_o = !crate_enable_i ? 1'b1      :
                       hskbus_local_i  ? dbg_rx_i  :
                                         turf_line;

    //////////////////////////////////////////////////
    // Upstream, from the SURFs
    //////////////////////////////////////////////////

    // Disabled bridge looks like an idle line
    assign crate_line = crate_enable_i ? surf_tx_i : 1'b1;

    hsk_uart_rx u_rx (
        .init_clk   (init_clk),
        .reset_i    (reset_i),
        .line_i     (crate_line),
        .rx_byte_o  (rx_byte),
        .rx_bytes_o (hskbus_rx_bytes_o)
    );

    hsk_byte_fifo u_fifo (
        .init_clk   (init_clk),
        .reset_i    (reset_i),
        .wr_i       (rx_byte),
        .pop_i      (tx_pop),
        .head_o     (fifo_head),
        .overflow_o (overflow_o)
    );

    hsk_uart_tx u_tx (
        .init_clk (init_clk),
        .reset_i  (reset_i),
        .head_i   (fifo_head),
        .pop_o    (tx_pop),
        .line_o   (tx_line)
    );

    // Unselected output parks high
    assign f_ttx_o  = hskbus_local_i ? 1'b1 : tx_line;
    assign dbg_tx_o = hskbus_local_i ? tx_line : 1'b1;

endmodule

/* verification/hsk_bridge_tb.sv */
`timescale 1ns/1ps
`include "hsk_consts.svh"

module hsk_bridge_tb;

    // Total frames driven over the run
    localparam int FRAMES_SENT    = 44;
    localparam int TIMEOUT_CYCLES = FRAMES_SENT * 10 * `HSK_BAUD_PERIOD * 2 + 2000;
    // Burst stop bit of 0.8 bit period
    localparam int SHORT_STOP     = `HSK_BAUD_PERIOD * 4 / 5;

    logic               init_clk;
    logic               reset_i;
    logic               surf_tx_i;
    logic               trx_i;
    logic               tctrl_b_i;
    logic               dbg_rx_i;
    logic               hskbus_local_i;
    logic               crate_enable_i;
    logic               surf_rx_o;
    logic               f_ttx_o;
    logic               dbg_tx_o;
    logic               overflow_o;
    hsk_pkg::byte_cnt_t hskbus_rx_bytes_o;

    integer             seed = 89368;
    int                 errors = 0;
    int                 cycles = 0;
    // High when bytes should leave on the debug port
    logic               exp_dbg = 1'b0;
    hsk_pkg::byte_cnt_t count_exp = '0;
    hsk_pkg::byte_t     exp_q [$];
    hsk_pkg::byte_t     rx_q [$];

    hsk_bridge_top dut_i (.*);

    initial begin
        init_clk = 1'b0;
        forever #2 init_clk = ~init_clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Outputs settled 1 ns past the rising edge
    task automatic sample_point();
        @(posedge init_clk);
        #1;
    endtask

    // Reference model of the downstream routing
    function automatic logic expect_surf_rx(input logic en, input logic local_sel,
                                            input logic tctrl_b, input logic trx,
                                            input logic dbg);
        if (!en) return 1'b1;
        if (local_sel) return dbg;
        if (tctrl_b) return 1'b1;
        return trx;
    endfunction

    function automatic logic tx_line(input logic use_dbg);
        return use_dbg ? dbg_tx_o : f_ttx_o;
    endfunction

    // Starts and ends on a falling edge
    task automatic send_frame(input hsk_pkg::byte_t data, input int stop_cycles,
                              input logic stop_lvl);
        int i;
        surf_tx_i = 1'b0;
        repeat (`HSK_BAUD_PERIOD) @(negedge init_clk);
        // LSB first
        for (i = 0; i < 8; i++) begin
            surf_tx_i = data[i];
            repeat (`HSK_BAUD_PERIOD) @(negedge init_clk);
        end
        surf_tx_i = stop_lvl;
        repeat (stop_cycles) @(negedge init_clk);
        surf_tx_i = 1'b1;
    endtask

    task automatic send_random(input int n, input int stop_cycles, input logic counted);
        int          k;
        logic [31:0] rnd;
        for (k = 0; k < n; k++) begin
            rnd = $random(seed);
            if (counted) begin
                exp_q.push_back(rnd[7:0]);
                count_exp = count_exp + 1'b1;
            end
            send_frame(rnd[7:0], stop_cycles, 1'b1);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            sample_point();
        end
        // Rest of the last stop bit
        repeat (`HSK_BAUD_PERIOD) sample_point();
        @(negedge init_clk);
    endtask

    task automatic check_count();
        assert (hskbus_rx_bytes_o === count_exp) else begin
            errors++;
            $display("Mismatch hskbus_rx_bytes_o: got 0x%h expected 0x%h",
                     hskbus_rx_bytes_o, count_exp);
        end
    endtask

    // Entered in the first cycle of a start bit
    task automatic capture_frame(input logic use_dbg);
        hsk_pkg::byte_t got;
        string          name;
        int             i;
        name = use_dbg ? "dbg_tx_o" : "f_ttx_o";
        repeat (`HSK_BAUD_PERIOD / 2) sample_point();
        assert (tx_line(use_dbg) === 1'b0) else begin
            errors++;
            $display("Start bit on %s did not stay low to mid-bit", name);
        end
        for (i = 0; i < 8; i++) begin
            repeat (`HSK_BAUD_PERIOD) sample_point();
            got[i] = tx_line(use_dbg);
        end
        repeat (`HSK_BAUD_PERIOD) sample_point();
        assert (tx_line(use_dbg) === 1'b1) else begin
            errors++;
            $display("Mismatch %s stop bit: got 0x%h expected 0x1", name, tx_line(use_dbg));
        end
        assert (use_dbg === exp_dbg) else begin
            errors++;
            $display("Byte 0x%h left on %s, the unselected output", got, name);
        end
        rx_q.push_back(got);
    endtask

    //////////////////////////////////////////////////
    // Monitors and checkers
    //////////////////////////////////////////////////

    initial begin : ttx_monitor
        forever begin
            sample_point();
            if (reset_i === 1'b0 && f_ttx_o === 1'b0) begin
                capture_frame(1'b0);
            end
        end
    end

    initial begin : dbg_monitor
        forever begin
            sample_point();
            if (reset_i === 1'b0 && dbg_tx_o === 1'b0) begin
                capture_frame(1'b1);
            end
        end
    end

    // Forwarded bytes must match in order and bit-exact
    initial begin : byte_checker
        hsk_pkg::byte_t got;
        hsk_pkg::byte_t want;
        forever begin
            sample_point();
            if (rx_q.size() != 0) begin
                got = rx_q.pop_front();
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Byte 0x%h was forwarded but none was expected", got);
                end else begin
                    want = exp_q.pop_front();
                    assert (got === want) else begin
                        errors++;
                        $display("Mismatch serial byte: got 0x%h expected 0x%h", got, want);
                    end
                end
            end
        end
    end

    // Downstream route and parked output checked every cycle
    initial begin : line_checker
        logic want;
        forever begin
            sample_point();
            if (reset_i === 1'b0) begin
                want = expect_surf_rx(crate_enable_i, hskbus_local_i, tctrl_b_i,
                                      trx_i, dbg_rx_i);
                assert (surf_rx_o === want) else begin
                    errors++;
                    $display("Mismatch surf_rx_o: got 0x%h expected 0x%h", surf_rx_o, want);
                end
                assert (hskbus_local_i ? f_ttx_o === 1'b1 : dbg_tx_o === 1'b1) else begin
                    errors++;
                    $display("Unselected transmit output left the idle level");
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge init_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d bytes still expected",
                 cycles, exp_q.size());
        $display("Errors: %0d", errors);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        int          k;
        logic [31:0] rnd;
        reset_i        = 1'b1;
        surf_tx_i      = 1'b1;
        trx_i          = 1'b1;
        tctrl_b_i      = 1'b1;
        dbg_rx_i       = 1'b1;
        hskbus_local_i = 1'b0;
        crate_enable_i = 1'b1;
        repeat (4) @(negedge init_clk);
        reset_i = 1'b0;
        sample_point();
        assert (f_ttx_o && dbg_tx_o && !overflow_o && hskbus_rx_bytes_o == '0) else begin
            errors++;
            $display("Outputs not at their reset values after reset");
        end
        @(negedge init_clk);

        // TURF route
        send_random(8, `HSK_BAUD_PERIOD, 1'b1);
        wait_drained();
        check_count();

        // Debug route
        hskbus_local_i = 1'b1;
        exp_dbg        = 1'b1;
        send_random(8, `HSK_BAUD_PERIOD, 1'b1);
        wait_drained();
        check_count();

        // Every select combination then random downstream lines
        for (k = 0; k < 32; k++) begin
            {crate_enable_i, hskbus_local_i, tctrl_b_i, trx_i, dbg_rx_i} = k[4:0];
            @(negedge init_clk);
        end
        for (k = 0; k < 64; k++) begin
            rnd = $random(seed);
            {crate_enable_i, hskbus_local_i, tctrl_b_i, trx_i, dbg_rx_i} = rnd[4:0];
            @(negedge init_clk);
        end
        {crate_enable_i, hskbus_local_i, tctrl_b_i, trx_i, dbg_rx_i} = 5'b10111;
        exp_dbg = 1'b0;

        // Nothing forwarded or counted with the bridge off
        crate_enable_i = 1'b0;
        send_random(2, `HSK_BAUD_PERIOD, 1'b0);
        repeat (2 * `HSK_BAUD_PERIOD) @(negedge init_clk);
        check_count();
        crate_enable_i = 1'b1;
        // Framing error from a low stop bit
        send_frame(8'h5a, `HSK_BAUD_PERIOD, 1'b0);
        repeat (2 * `HSK_BAUD_PERIOD) @(negedge init_clk);
        check_count();
        // Receiver recovers
        send_random(1, `HSK_BAUD_PERIOD, 1'b1);
        wait_drained();
        check_count();

        // FIFO absorbs a slightly fast sender
        send_random(24, SHORT_STOP, 1'b1);
        wait_drained();
        check_count();
        assert (overflow_o === 1'b0) else begin
            errors++;
            $display("Mismatch overflow_o: got 0x%h expected 0x0", overflow_o);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+design
design/hsk_pkg.sv
design/hsk_uart_rx.sv
design/hsk_byte_fifo.sv
design/hsk_uart_tx.sv
design/hsk_bridge_top.sv
verification/hsk_bridge_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP      = hsk_bridge_tb
FILELIST = list.f
PASS_MSG = Test passed

.PHONY: sim clean

# Build, run, then pass only if the pass line shows up
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf obj_dir
